//--- src/fetch_pkg.sv
package fetch_pkg;

  // datapath and address width of the RV32 core
  localparam int xlen = 32;

  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000; // simulation boot address

  // cache geometry: 16 lines of 4 words each, 256 bytes in total
  localparam int line_words = 4;
  localparam int line_count = 16;
  localparam int offset_bits = 4;
  localparam int index_bits = 4;
  localparam int tag_bits = xlen - offset_bits - index_bits;

  // opcode[6:2] shared by beq, bne, blt, bge, bltu and bgeu
  localparam logic [4:0] opcode_branch = 5'b11000;

endpackage

//--- src/mem_read_if.sv
interface mem_read_if;
  import fetch_pkg::*;

  // address phase, one word address per request
  logic [xlen-1:0] addr;
  logic            addr_valid;
  logic            addr_ready;

  // data phase, one word back per accepted address and in order
  logic [xlen-1:0] data;
  logic            data_valid;
  logic            data_ready;

  modport cache (
    output addr, addr_valid, data_ready,
    input  addr_ready, data, data_valid
  );

  modport mem (
    input  addr, addr_valid, data_ready,
    output addr_ready, data, data_valid
  );

endinterface

//--- src/icache.sv
module icache (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       fence_i,
  input  logic [fetch_pkg::xlen-1:0] fetch_addr,
  output logic                       hit,
  output logic [fetch_pkg::xlen-1:0] inst,
  mem_read_if.cache                  mem
);
  import fetch_pkg::*;

  localparam int word_bits = offset_bits - 2;
  localparam logic [word_bits-1:0] last_word = word_bits'(line_words - 1);

  typedef enum logic {
    state_idle,
    state_refill
  } state_t;

  state_t state;

  logic [line_count-1:0] valid;
  logic [tag_bits-1:0]   tag_arr  [line_count];
  logic [xlen-1:0]       data_arr [line_count][line_words];

  logic [tag_bits-1:0]   lookup_tag;
  logic [index_bits-1:0] lookup_index;
  logic [word_bits-1:0]  lookup_word;

  logic [tag_bits-1:0]   refill_tag;
  logic [index_bits-1:0] refill_index;
  logic [word_bits-1:0]  word_cnt; // next word of the line to request and write
  logic                  addr_valid_r;

  logic start_refill;
  logic addr_fire;
  logic data_fire;

  assign lookup_tag   = fetch_addr[xlen-1 -: tag_bits];
  assign lookup_index = fetch_addr[offset_bits +: index_bits];
  assign lookup_word  = fetch_addr[2 +: word_bits];

  // lookup is purely combinational so a hit costs no cycle
  assign hit  = valid[lookup_index] && (tag_arr[lookup_index] == lookup_tag);
  assign inst = data_arr[lookup_index][lookup_word];

  assign start_refill = (state == state_idle) && !hit;
  assign addr_fire    = mem.addr_valid && mem.addr_ready;
  assign data_fire    = mem.data_valid && mem.data_ready;

  assign mem.addr       = {refill_tag, refill_index, word_cnt, 2'b00};
  assign mem.addr_valid = addr_valid_r;
  assign mem.data_ready = (state == state_refill) && !addr_valid_r; // only once the address is out

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= state_idle;
      valid        <= '0;
      addr_valid_r <= 1'b0;
      word_cnt     <= '0;
    end else begin
      // set below wins, so a refill that ends together with fence.i keeps its line
      if (fence_i) begin
        valid <= '0;
      end
      case (state)
        state_idle: begin
          if (start_refill) begin
            state                 <= state_refill;
            addr_valid_r          <= 1'b1;
            word_cnt              <= '0;
            valid[lookup_index]   <= 1'b0; // the line is rewritten from here on
          end
        end
        state_refill: begin
          if (addr_fire) begin
            addr_valid_r <= 1'b0;
          end
          if (data_fire) begin
            if (word_cnt == last_word) begin
              state               <= state_idle;
              valid[refill_index] <= 1'b1;
            end else begin
              word_cnt     <= word_cnt + 1'b1;
              addr_valid_r <= 1'b1;
            end
          end
        end
        default: state <= state_idle;
      endcase
    end
  end

  // arrays and the line being refilled
  always_ff @(posedge clock) begin
    if (start_refill) begin
      refill_tag            <= lookup_tag;
      refill_index          <= lookup_index;
      tag_arr[lookup_index] <= lookup_tag;
    end
    if (state == state_refill && data_fire) begin
      data_arr[refill_index][word_cnt] <= mem.data;
    end
  end

  // a request that is not accepted must be held unchanged for the memory side
  addr_held: assert property (
    @(posedge clock) disable iff (reset)
    mem.addr_valid && !mem.addr_ready |=> mem.addr_valid && $stable(mem.addr)
  );

endmodule

//--- src/fetch_unit.sv
module fetch_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       redirect_branch,
  input  logic                       redirect_trap,
  input  logic [fetch_pkg::xlen-1:0] redirect_branch_pc,
  input  logic [fetch_pkg::xlen-1:0] redirect_trap_pc,
  input  logic                       hit,
  input  logic [fetch_pkg::xlen-1:0] inst,
  output logic [fetch_pkg::xlen-1:0] fetch_addr,
  input  logic                       out_ready,
  output logic                       out_valid,
  output logic [fetch_pkg::xlen-1:0] out_pc,
  output logic [fetch_pkg::xlen-1:0] out_inst
);
  import fetch_pkg::*;

  logic [xlen-1:0] fetch_pc;
  logic            out_valid_r;

  // redirect that met a miss, applied when the refill ends
  logic            pend;
  logic [xlen-1:0] pend_pc;

  logic            redirect;
  logic [xlen-1:0] redirect_pc;

  logic [xlen-1:0] imm_b;
  logic            predict_taken;
  logic [xlen-1:0] pred_pc;
  logic            load;

  assign redirect    = redirect_branch || redirect_trap;
  assign redirect_pc = redirect_trap ? redirect_trap_pc : redirect_branch_pc; // trap has priority

  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

  // backward conditional branches are predicted taken, everything else falls through
  assign predict_taken = (inst[6:2] == opcode_branch) && inst[31];
  assign pred_pc       = fetch_pc + (predict_taken ? imm_b : xlen'(4));

  // the output register takes a new pair when it is empty or drained this cycle
  assign load = !redirect && !pend && hit && (!out_valid_r || out_ready);

  assign fetch_addr = fetch_pc;
  assign out_valid  = out_valid_r && !redirect; // the held item is killed by a redirect

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc    <= reset_pc;
      out_valid_r <= 1'b0;
      pend        <= 1'b0;
    end else if (redirect) begin
      out_valid_r <= 1'b0;
      if (hit) begin
        fetch_pc <= redirect_pc;
        pend     <= 1'b0;
      end else begin
        pend <= 1'b1; // the cache is busy with a refill, wait for it
      end
    end else if (pend) begin
      if (hit) begin
        fetch_pc <= pend_pc;
        pend     <= 1'b0;
      end
    end else if (!out_valid_r || out_ready) begin
      out_valid_r <= hit;
      if (hit) begin
        fetch_pc <= pred_pc;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (redirect && !hit) begin
      pend_pc <= redirect_pc;
    end
    if (load) begin
      out_pc   <= fetch_pc;
      out_inst <= inst;
    end
  end

  // decode sees a stable pair while it stalls
  out_held: assert property (
    @(posedge clock) disable iff (reset)
    out_valid && !out_ready && !redirect |=> $stable(out_pc) && $stable(out_inst)
  );

endmodule

//--- src/fetch_perf.sv
module fetch_perf (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       out_valid,
  input  logic                       out_ready,
  input  logic                       miss_start,
  output logic [fetch_pkg::xlen-1:0] inst_count,
  output logic [fetch_pkg::xlen-1:0] miss_count,
  output logic [fetch_pkg::xlen-1:0] empty_count
);
  import fetch_pkg::*;

  // counters stop at all ones instead of wrapping
  function automatic logic [xlen-1:0] sat_inc(input logic [xlen-1:0] count, input logic enable);
    logic [xlen-1:0] result;
    result = count;
    if (enable && count != '1) begin
      result = count + 1'b1;
    end
    return result;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_count  <= '0;
      miss_count  <= '0;
      empty_count <= '0;
    end else begin
      inst_count  <= sat_inc(inst_count, out_valid && out_ready);
      miss_count  <= sat_inc(miss_count, miss_start);
      empty_count <= sat_inc(empty_count, !out_valid); // includes stalls behind a refill
    end
  end

endmodule

//--- src/fetch_front.sv
module fetch_front (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       fence_i,
  input  logic                       redirect_branch,
  input  logic [fetch_pkg::xlen-1:0] redirect_branch_pc,
  input  logic                       redirect_trap,
  input  logic [fetch_pkg::xlen-1:0] redirect_trap_pc,
  input  logic                       out_ready,
  output logic                       out_valid,
  output logic [fetch_pkg::xlen-1:0] out_pc,
  output logic [fetch_pkg::xlen-1:0] out_inst,
  output logic [fetch_pkg::xlen-1:0] mem_addr,
  output logic                       mem_addr_valid,
  input  logic                       mem_addr_ready,
  input  logic [fetch_pkg::xlen-1:0] mem_data,
  input  logic                       mem_data_valid,
  output logic                       mem_data_ready,
  output logic [fetch_pkg::xlen-1:0] inst_count,
  output logic [fetch_pkg::xlen-1:0] miss_count,
  output logic [fetch_pkg::xlen-1:0] empty_count
);
  import fetch_pkg::*;

  mem_read_if mem_bus ();

  logic [xlen-1:0] fetch_addr;
  logic            hit;
  logic [xlen-1:0] inst;
  logic            miss_start;

  assign mem_addr           = mem_bus.addr;
  assign mem_addr_valid     = mem_bus.addr_valid;
  assign mem_data_ready     = mem_bus.data_ready;
  assign mem_bus.addr_ready = mem_addr_ready;
  assign mem_bus.data       = mem_data;
  assign mem_bus.data_valid = mem_data_valid;

  // first word of a line accepted by memory marks one refill
  assign miss_start = mem_bus.addr_valid && mem_bus.addr_ready &&
                      (mem_bus.addr[offset_bits-1:2] == '0);

  icache icache_inst (
    .clock      (clock),
    .reset      (reset),
    .fence_i    (fence_i),
    .fetch_addr (fetch_addr),
    .hit        (hit),
    .inst       (inst),
    .mem        (mem_bus)
  );

  fetch_unit fetch_unit_inst (
    .clock              (clock),
    .reset              (reset),
    .redirect_branch    (redirect_branch),
    .redirect_trap      (redirect_trap),
    .redirect_branch_pc (redirect_branch_pc),
    .redirect_trap_pc   (redirect_trap_pc),
    .hit                (hit),
    .inst               (inst),
    .fetch_addr         (fetch_addr),
    .out_ready          (out_ready),
    .out_valid          (out_valid),
    .out_pc             (out_pc),
    .out_inst           (out_inst)
  );

  fetch_perf fetch_perf_inst (
    .clock       (clock),
    .reset       (reset),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .miss_start  (miss_start),
    .inst_count  (inst_count),
    .miss_count  (miss_count),
    .empty_count (empty_count)
  );

endmodule

//--- bench/fetch_front_tb.sv
module fetch_front_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  localparam int mem_words = 256;
  localparam int shadow_lines = 16;
  localparam int shadow_index_bits = 4;
  localparam int row_count = 10;
  localparam int timeout_cycles = row_count * 64;

  typedef enum logic [2:0] {
    act_none,
    act_branch,
    act_trap,
    act_both,
    act_fence
  } action_t;

  typedef struct {
    int              at_count;
    action_t         action;
    logic [xlen-1:0] branch_pc;
    logic [xlen-1:0] trap_pc;
  } row_t;

  logic            clock;
  logic            reset;
  logic            fence_i;
  logic            redirect_branch;
  logic [xlen-1:0] redirect_branch_pc;
  logic            redirect_trap;
  logic [xlen-1:0] redirect_trap_pc;
  logic            out_ready;
  logic            out_valid;
  logic [xlen-1:0] out_pc;
  logic [xlen-1:0] out_inst;
  logic [xlen-1:0] mem_addr;
  logic            mem_addr_valid;
  logic            mem_addr_ready;
  logic [xlen-1:0] mem_data;
  logic            mem_data_valid;
  logic            mem_data_ready;
  logic [xlen-1:0] inst_count;
  logic [xlen-1:0] miss_count;
  logic [xlen-1:0] empty_count;

  row_t            rows [row_count];
  logic [xlen-1:0] mem_arr [mem_words];
  logic [shadow_lines-1:0] shadow_valid;
  logic [xlen-offset_bits-shadow_index_bits-1:0] shadow_tag [shadow_lines];

  logic [31:0]     lfsr_state;
  logic [xlen-1:0] exp_pc;
  logic [xlen-1:0] rsp_addr;
  logic [xlen-1:0] last_addr;
  logic            rsp_busy;
  logic            data_shown;
  logic            held_before_fence;
  int              rsp_delay;
  int              transfers;
  int              empties;
  int              refills;
  int              errors;
  int              row_idx;
  int              cycles;

  fetch_front fetch_front_inst (
    .clock              (clock),
    .reset              (reset),
    .fence_i            (fence_i),
    .redirect_branch    (redirect_branch),
    .redirect_branch_pc (redirect_branch_pc),
    .redirect_trap      (redirect_trap),
    .redirect_trap_pc   (redirect_trap_pc),
    .out_ready          (out_ready),
    .out_valid          (out_valid),
    .out_pc             (out_pc),
    .out_inst           (out_inst),
    .mem_addr           (mem_addr),
    .mem_addr_valid     (mem_addr_valid),
    .mem_addr_ready     (mem_addr_ready),
    .mem_data           (mem_data),
    .mem_data_valid     (mem_data_valid),
    .mem_data_ready     (mem_data_ready),
    .inst_count         (inst_count),
    .miss_count         (miss_count),
    .empty_count        (empty_count)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [3:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[2:0], lfsr_state[0]};
    end
  endtask

  // addi x0, x0, imm with an immediate folded from the whole address
  function automatic logic [xlen-1:0] fill_word(input logic [xlen-1:0] addr);
    logic [11:0] imm;
    imm = addr[11:0] ^ addr[23:12] ^ {4'h0, addr[31:24]};
    return {imm, 20'h00013};
  endfunction

  // static prediction straight from the RV32 B-type encoding
  function automatic logic [xlen-1:0] predict_next(input logic [xlen-1:0] pc,
                                                   input logic [xlen-1:0] word);
    logic [xlen-1:0] step;
    step = 32'd4;
    if (word[6:2] == 5'b11000 && word[31]) begin
      step = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    end
    return pc + step;
  endfunction

  // the shadow tag table holds the lines refilled since reset or the last fence.i
  function automatic logic line_cached(input logic [xlen-1:0] addr);
    logic [shadow_index_bits-1:0] idx;
    idx = addr[offset_bits +: shadow_index_bits];
    return shadow_valid[idx] &&
           shadow_tag[idx] == addr[xlen-1:offset_bits+shadow_index_bits];
  endfunction

  task automatic load_memory();
    logic [xlen-1:0] prog_addr [5];
    logic [xlen-1:0] prog_inst [5];
    prog_addr[0] = reset_pc + 32'h008; // addi x1, x0, -1 has bit 31 set but is no branch
    prog_inst[0] = 32'hfff0_0093;
    prog_addr[1] = reset_pc + 32'h010; // forward beq, falls through
    prog_inst[1] = 32'h0000_0863;
    prog_addr[2] = reset_pc + 32'h040; // backward beq to +0x020
    prog_inst[2] = 32'hfe00_00e3;
    prog_addr[3] = reset_pc + 32'h200; // backward beq to +0x1e0
    prog_inst[3] = 32'hfe00_00e3;
    prog_addr[4] = reset_pc + 32'h120;
    prog_inst[4] = 32'h0020_8133;
    for (int i = 0; i < mem_words; i++) begin
      mem_arr[i] = fill_word(reset_pc + 32'(i * 4));
    end
    for (int i = 0; i < 5; i++) begin
      mem_arr[prog_addr[i][9:2]] = prog_inst[i];
    end
  endtask

  task automatic load_rows();
    rows[0] = '{6, act_none, 32'h0, 32'h0};
    rows[1] = '{14, act_branch, reset_pc + 32'h100, 32'h0};
    rows[2] = '{18, act_trap, 32'h0, reset_pc + 32'h1c0};
    rows[3] = '{22, act_both, reset_pc + 32'h300, reset_pc + 32'h1f0}; // the trap target wins
    rows[4] = '{30, act_fence, 32'h0, 32'h0};
    rows[5] = '{36, act_none, 32'h0, 32'h0};
    rows[6] = '{40, act_branch, reset_pc, 32'h0};
    rows[7] = '{46, act_trap, 32'h0, reset_pc + 32'h100};
    rows[8] = '{50, act_branch, reset_pc + 32'h0c0, 32'h0};
    rows[9] = '{56, act_none, 32'h0, 32'h0};
  endtask

  task automatic monitor_outputs();
    logic [xlen-1:0] word;
    if (redirect_branch || redirect_trap) begin
      if (out_valid) begin
        errors++;
        $display("Error: out_valid is %h, expected %h in a redirect cycle", out_valid, 1'b0);
      end
      exp_pc = redirect_trap ? redirect_trap_pc : redirect_branch_pc;
      held_before_fence = 1'b0;
    end else if (out_valid && out_ready) begin
      word = mem_arr[exp_pc[9:2]];
      if (out_pc !== exp_pc) begin
        errors++;
        $display("Error: out_pc is %h, expected %h", out_pc, exp_pc);
      end
      if (out_inst !== word) begin
        errors++;
        $display("Error: out_inst is %h, expected %h", out_inst, word);
      end
      if (!line_cached(exp_pc) && !held_before_fence) begin
        errors++;
        $display("the word at %h was delivered although its line was not refilled", exp_pc);
      end
      held_before_fence = 1'b0;
      exp_pc = predict_next(exp_pc, word);
      transfers++;
    end
    if (!out_valid) begin
      empties++;
    end
  endtask

  task automatic serve_memory();
    logic [3:0]                  bits;
    logic [shadow_index_bits-1:0] idx;
    if (fence_i) begin
      shadow_valid = '0;
      held_before_fence = 1'b1; // the output register may still hold a word read before it
    end
    if (mem_data_valid && mem_data_ready) begin
      idx = rsp_addr[offset_bits +: shadow_index_bits];
      if (rsp_addr[offset_bits-1:2] == 2'(line_words - 1)) begin
        shadow_valid[idx] = 1'b1; // the whole line is in
      end
      rsp_busy = 1'b0;
      data_shown = 1'b0;
      mem_data_valid <= 1'b0;
    end
    if (mem_addr_valid && mem_addr_ready) begin
      idx = mem_addr[offset_bits +: shadow_index_bits];
      if (rsp_busy) begin
        errors++;
        $display("a new address was accepted while a word was still outstanding");
      end
      if (mem_addr[offset_bits-1:0] == '0) begin
        if (line_cached(mem_addr)) begin
          errors++;
          $display("line at %h was refilled although it was cached", mem_addr);
        end
        shadow_valid[idx] = 1'b0;
        shadow_tag[idx] = mem_addr[xlen-1:offset_bits+shadow_index_bits];
        refills++;
      end else if (mem_addr !== last_addr + 32'd4) begin
        errors++;
        $display("Error: mem_addr is %h, expected %h", mem_addr, last_addr + 32'd4);
      end
      last_addr = mem_addr;
      rsp_busy = 1'b1;
      rsp_addr = mem_addr;
      random_bits(2, bits);
      rsp_delay = int'(bits);
    end
    if (rsp_busy && !data_shown) begin
      if (rsp_delay == 0) begin
        mem_data_valid <= 1'b1;
        mem_data <= mem_arr[rsp_addr[9:2]];
        data_shown = 1'b1;
      end else begin
        rsp_delay--;
      end
    end
    random_bits(3, bits);
    mem_addr_ready <= (bits != 4'd0); // a gap about one cycle in eight
  endtask

  task automatic drive_controls();
    logic [3:0] bits;
    redirect_branch <= 1'b0;
    redirect_trap <= 1'b0;
    fence_i <= 1'b0;
    random_bits(2, bits);
    out_ready <= (bits != 4'd0);
    if (row_idx < row_count && transfers >= rows[row_idx].at_count) begin
      redirect_branch_pc <= rows[row_idx].branch_pc;
      redirect_trap_pc <= rows[row_idx].trap_pc;
      case (rows[row_idx].action)
        act_branch: redirect_branch <= 1'b1;
        act_trap:   redirect_trap <= 1'b1;
        act_both: begin
          redirect_branch <= 1'b1;
          redirect_trap <= 1'b1;
        end
        act_fence:  fence_i <= 1'b1;
        default: ;
      endcase
      row_idx++;
    end
  endtask

  task automatic step_cycle();
    monitor_outputs();
    serve_memory();
    drive_controls();
  endtask

  task automatic compare_counters();
    if (inst_count !== 32'(transfers)) begin
      errors++;
      $display("Error: inst_count is %h, expected %h", inst_count, 32'(transfers));
    end
    if (miss_count !== 32'(refills)) begin
      errors++;
      $display("Error: miss_count is %h, expected %h", miss_count, 32'(refills));
    end
    if (empty_count !== 32'(empties)) begin
      errors++;
      $display("Error: empty_count is %h, expected %h", empty_count, 32'(empties));
    end
  endtask

  initial begin
    reset = 1'b1;
    fence_i = 1'b0;
    redirect_branch = 1'b0;
    redirect_branch_pc = '0;
    redirect_trap = 1'b0;
    redirect_trap_pc = '0;
    out_ready = 1'b0;
    mem_addr_ready = 1'b0;
    mem_data = '0;
    mem_data_valid = 1'b0;
    lfsr_state = 32'h3e32_1cfc;
    shadow_valid = '0;
    exp_pc = reset_pc;
    rsp_addr = '0;
    last_addr = '0;
    rsp_busy = 1'b0;
    data_shown = 1'b0;
    held_before_fence = 1'b0;
    rsp_delay = 0;
    transfers = 0;
    empties = 0;
    refills = 0;
    errors = 0;
    row_idx = 0;
    load_memory();
    load_rows();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    while (row_idx < row_count) begin
      @(posedge clock);
      step_cycle();
    end
    repeat (4) begin
      @(posedge clock);
      step_cycle();
    end
    @(posedge clock);
    compare_counters();
    $display("errors %0d, transfers %0d, refills %0d, empty cycles %0d",
             errors, transfers, refills, empties);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clock);
      cycles++;
    end
    $display("run did not finish within %0d cycles", timeout_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- fetch_front.f
src/fetch_pkg.sv
src/mem_read_if.sv
src/icache.sv
src/fetch_unit.sv
src/fetch_perf.sv
src/fetch_front.sv
bench/fetch_front_tb.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

TOP       ?= fetch_front_tb
FILELIST  ?= fetch_front.f
VERILATOR ?= verilator
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
